// ==== common/img_params.svh ====
`ifndef IMG_PARAMS_SVH
`define IMG_PARAMS_SVH

// ==============================
// Pixel and word widths
// ==============================
`define IMG_PIXEL_BITS 12
`define IMG_WORD_BITS 16

// Words of command header stored ahead of the pixels
`define IMG_HEADER_WORDS 8

// ==============================
// Frame buffer geometry
// ==============================
`define IMG_BLOCK_WORDS 1024
`define IMG_BLOCKS 2

// ==============================
// Highlight and shadow statistics
// ==============================
`define IMG_STAT_BITS 18
// Tile edge is 2**IMG_STAT_TILE_BITS pixels
`define IMG_STAT_TILE_BITS 2
// Top pixel bits tested for a tone
`define IMG_TONE_BITS 7

`endif

// ==== common/img_frame_pkg.sv ====
`include "img_params.svh"

package img_frame_pkg;

    // One sensor pixel
    typedef logic [`IMG_PIXEL_BITS-1:0] pixel_t;

    // One word of the stored frame
    typedef logic [`IMG_WORD_BITS-1:0] word_t;

    // Header, most significant word is stored first
    typedef logic [`IMG_HEADER_WORDS*`IMG_WORD_BITS-1:0] header_t;

    // Fletcher result as {high sum, low sum}
    typedef logic [2*`IMG_WORD_BITS-1:0] checksum_t;

    // Highlight or shadow count
    typedef logic [`IMG_STAT_BITS-1:0] stat_count_t;

endpackage

// ==== common/img_buf_pkg.sv ====
`include "img_params.svh"

package img_buf_pkg;

    // Which block of the frame buffer
    typedef logic [$clog2(`IMG_BLOCKS)-1:0] block_t;

    // Word address inside one block
    typedef logic [$clog2(`IMG_BLOCK_WORDS)-1:0] buf_addr_t;

    // Words in one capture, one bit wider so a full block fits
    typedef logic [$clog2(`IMG_BLOCK_WORDS):0] word_count_t;

endpackage

// ==== capture/fletcher_checksum.sv ====
`timescale 1ns/1ps
`include "img_params.svh"

module fletcher_checksum (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      clear,
    input  logic                      en,
    input  img_frame_pkg::word_t      din,
    output img_frame_pkg::checksum_t  sum
);
    import img_frame_pkg::*;

    // Both halves run modulo 2**16 - 1
    localparam logic [`IMG_WORD_BITS:0] modulus = {1'b0, {`IMG_WORD_BITS{1'b1}}};

    word_t low_q;
    word_t high_q;
    word_t low_next;
    word_t high_next;

    function automatic word_t add_mod(input word_t a, input word_t b);
        logic [`IMG_WORD_BITS:0] total;
        total = {1'b0, a} + {1'b0, b};
        // One subtraction is enough, both operands stay below twice the modulus
        if (total >= modulus) begin
            total = total - modulus;
        end
        return total[`IMG_WORD_BITS-1:0];
    endfunction

    assign low_next  = add_mod(low_q, din);
    assign high_next = add_mod(high_q, low_next);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            low_q  <= '0;
            high_q <= '0;
        end else if (clear) begin
            low_q  <= '0;
            high_q <= '0;
        end else if (en) begin
            low_q  <= low_next;
            high_q <= high_next;
        end
    end

    assign sum = {high_q, low_q};

endmodule

// ==== capture/pixel_capture.sv ====
`timescale 1ns/1ps
`include "img_params.svh"

module pixel_capture (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         start,
    input  img_frame_pkg::header_t       header,
    input  img_frame_pkg::pixel_t        img_d,
    input  logic                         img_fv,
    input  logic                         img_lv,
    output logic                         wr_en,
    output img_frame_pkg::word_t         wr_data,
    output logic                         done,
    output img_buf_pkg::word_count_t     word_count,
    output img_frame_pkg::stat_count_t   highlight_count,
    output img_frame_pkg::stat_count_t   shadow_count
);
    import img_frame_pkg::*;

    localparam int step_bits = $clog2(`IMG_HEADER_WORDS);
    localparam logic [step_bits-1:0] last_header = step_bits'(`IMG_HEADER_WORDS - 1);
    // Checksum phase: high word, low word, then done
    localparam logic [step_bits-1:0] checksum_end = step_bits'(2);

    typedef enum logic [2:0] {
        s_idle,
        s_clear,
        s_header,
        s_wait_frame,
        s_frame,
        s_checksum
    } state_t;

    state_t                           state;
    logic [step_bits-1:0]             step;
    header_t                          hdr_q;
    pixel_t                           img_d_q;
    logic                             fv_q;
    logic                             lv_q;
    logic                             fv_prev;
    logic                             lv_prev;
    logic [`IMG_STAT_TILE_BITS-1:0]   col;
    logic [`IMG_STAT_TILE_BITS-1:0]   row;
    logic                             stat_hit;
    pixel_t                           stat_px;
    logic [`IMG_TONE_BITS-1:0]        stat_tone;
    checksum_t                        ck_sum;

    // ==============================
    // Sensor inputs and tile position
    // ==============================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fv_q     <= 1'b0;
            lv_q     <= 1'b0;
            fv_prev  <= 1'b0;
            lv_prev  <= 1'b0;
            col      <= '0;
            row      <= '0;
            stat_hit <= 1'b0;
        end else begin
            fv_q    <= img_fv;
            lv_q    <= img_lv;
            fv_prev <= fv_q;
            lv_prev <= lv_q;
            // col is the column of the pixel now in img_d_q
            if (!lv_q) begin
                col <= '0;
            end else begin
                col <= col + 1'b1;
            end
            // Next row once a line ends
            if (!fv_q) begin
                row <= '0;
            end else if (lv_prev && !lv_q) begin
                row <= row + 1'b1;
            end
            // Only the tile origin is sampled
            stat_hit <= (state == s_frame) && lv_q && (col == '0) && (row == '0);
        end
    end

    assign stat_tone = stat_px[`IMG_PIXEL_BITS-1 -: `IMG_TONE_BITS];

    // ==============================
    // Capture FSM
    // ==============================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state           <= s_idle;
            step            <= '0;
            wr_en           <= 1'b0;
            done            <= 1'b0;
            word_count      <= '0;
            highlight_count <= '0;
            shadow_count    <= '0;
        end else begin
            wr_en <= 1'b0;
            done  <= 1'b0;

            if (wr_en) begin
                word_count <= word_count + 1'b1;
            end

            if (stat_hit) begin
                if (&stat_tone) begin
                    highlight_count <= highlight_count + 1'b1;
                end
                if (~|stat_tone) begin
                    shadow_count <= shadow_count + 1'b1;
                end
            end

            case (state)
                s_idle: begin
                    if (start) begin
                        state <= s_clear;
                    end
                end
                // First header word leaves here
                s_clear: begin
                    word_count      <= '0;
                    highlight_count <= '0;
                    shadow_count    <= '0;
                    wr_en           <= 1'b1;
                    step            <= step_bits'(1);
                    state           <= s_header;
                end
                s_header: begin
                    wr_en <= 1'b1;
                    step  <= step + 1'b1;
                    if (step == last_header) begin
                        state <= s_wait_frame;
                    end
                end
                s_wait_frame: begin
                    if (fv_q && !fv_prev) begin
                        state <= s_frame;
                    end
                end
                s_frame: begin
                    wr_en <= lv_q;
                    if (!fv_q) begin
                        step  <= '0;
                        state <= s_checksum;
                    end
                end
                s_checksum: begin
                    step <= step + 1'b1;
                    if (step == checksum_end) begin
                        done  <= 1'b1;
                        state <= s_idle;
                    end else begin
                        wr_en <= 1'b1;
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    // Data path of the written words
    always_ff @(posedge clk) begin
        img_d_q <= img_d;
        stat_px <= img_d_q;
        case (state)
            s_idle: begin
                if (start) begin
                    hdr_q <= header;
                end
            end
            s_clear, s_header: begin
                wr_data <= hdr_q[$bits(header_t)-1 -: `IMG_WORD_BITS];
                hdr_q   <= hdr_q << `IMG_WORD_BITS;
            end
            s_frame: begin
                wr_data <= word_t'(img_d_q);
            end
            s_checksum: begin
                if (step == '0) begin
                    wr_data <= ck_sum[2*`IMG_WORD_BITS-1 -: `IMG_WORD_BITS];
                end else begin
                    wr_data <= ck_sum[`IMG_WORD_BITS-1:0];
                end
            end
            default: begin
            end
        endcase
    end

    // Checksum covers header and pixels and is frozen while its own words go out
    fletcher_checksum u_checksum (
        .clk    (clk),
        .arst_n (arst_n),
        .clear  (state == s_clear),
        .en     (wr_en && (state != s_checksum)),
        .din    (wr_data),
        .sum    (ck_sum)
    );

endmodule

// ==== src/frame_buffer.sv ====
`timescale 1ns/1ps
`include "img_params.svh"

module frame_buffer (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       capture_start,
    input  img_buf_pkg::block_t        capture_block,
    input  logic                       wr_en,
    input  img_frame_pkg::word_t       wr_data,
    input  logic                       readout_go,
    input  img_buf_pkg::block_t        readout_block,
    input  img_buf_pkg::word_count_t   readout_count,
    input  logic                       readout_trigger,
    output logic                       readout_ready,
    output img_frame_pkg::word_t       readout_data
);
    import img_frame_pkg::*;
    import img_buf_pkg::*;

    localparam int depth = `IMG_BLOCKS * `IMG_BLOCK_WORDS;

    word_t         mem [depth];
    block_t        wr_block;
    buf_addr_t     wr_ptr;
    block_t        rd_block;
    buf_addr_t     rd_ptr;
    word_count_t   fetch_left;
    logic          fetch;
    logic          consume;

    assign consume = readout_ready && readout_trigger;
    // Refill when the holding register is empty or is being emptied
    assign fetch   = (fetch_left != '0) && (!readout_ready || readout_trigger);

    // ==============================
    // Write side
    // ==============================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_block <= '0;
            wr_ptr   <= '0;
        end else if (capture_start) begin
            wr_block <= capture_block;
            wr_ptr   <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Memory array, readout_data doubles as the prefetch register
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[{wr_block, wr_ptr}] <= wr_data;
        end
        if (fetch) begin
            readout_data <= mem[{rd_block, rd_ptr}];
        end
    end

    // ==============================
    // Readout side
    // ==============================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_block      <= '0;
            rd_ptr        <= '0;
            fetch_left    <= '0;
            readout_ready <= 1'b0;
        end else if (readout_go) begin
            rd_block      <= readout_block;
            rd_ptr        <= '0;
            fetch_left    <= readout_count;
            readout_ready <= 1'b0;
        end else if (fetch) begin
            rd_ptr        <= rd_ptr + 1'b1;
            fetch_left    <= fetch_left - 1'b1;
            readout_ready <= 1'b1;
        end else if (consume) begin
            readout_ready <= 1'b0;
        end
    end

endmodule

// ==== src/img_controller.sv ====
`timescale 1ns/1ps

module img_controller (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         cmd_capture,
    input  logic                         cmd_readout,
    input  img_buf_pkg::block_t          cmd_ram_block,
    input  img_frame_pkg::header_t       cmd_header,
    input  img_frame_pkg::pixel_t        img_d,
    input  logic                         img_fv,
    input  logic                         img_lv,
    input  logic                         readout_trigger,
    output logic                         readout_start,
    output logic                         readout_ready,
    output img_frame_pkg::word_t         readout_data,
    output logic                         status_capture_done,
    output img_buf_pkg::word_count_t     status_capture_word_count,
    output img_frame_pkg::stat_count_t   status_capture_highlight_count,
    output img_frame_pkg::stat_count_t   status_capture_shadow_count
);
    import img_frame_pkg::*;
    import img_buf_pkg::*;

    typedef enum logic [1:0] {
        s_idle,
        s_capture,
        s_readout_start,
        s_readout
    } state_t;

    state_t        state;
    block_t        block_q;
    logic          capture_start;
    logic          readout_go;
    word_count_t   rd_count;
    logic          cap_wr_en;
    word_t         cap_wr_data;
    logic          cap_done;

    // ==============================
    // Command FSM
    // ==============================
    // Commands are only taken in idle, anything else is dropped
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state               <= s_idle;
            block_q             <= '0;
            capture_start       <= 1'b0;
            readout_go          <= 1'b0;
            readout_start       <= 1'b0;
            status_capture_done <= 1'b0;
            rd_count            <= '0;
        end else begin
            capture_start       <= 1'b0;
            readout_go          <= 1'b0;
            readout_start       <= 1'b0;
            status_capture_done <= 1'b0;

            case (state)
                s_idle: begin
                    if (cmd_capture) begin
                        block_q       <= cmd_ram_block;
                        capture_start <= 1'b1;
                        state         <= s_capture;
                    end else if (cmd_readout) begin
                        block_q    <= cmd_ram_block;
                        readout_go <= 1'b1;
                        rd_count   <= '0;
                        state      <= s_readout_start;
                    end
                end
                s_capture: begin
                    if (cap_done) begin
                        status_capture_done <= 1'b1;
                        state               <= s_idle;
                    end
                end
                // Buffer takes readout_go this cycle, first word follows start
                s_readout_start: begin
                    readout_start <= 1'b1;
                    state         <= s_readout;
                end
                s_readout: begin
                    if (rd_count == status_capture_word_count) begin
                        state <= s_idle;
                    end else if (readout_ready && readout_trigger) begin
                        rd_count <= rd_count + 1'b1;
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    // ==============================
    // Capture and storage
    // ==============================
    pixel_capture u_capture (
        .clk             (clk),
        .arst_n          (arst_n),
        .start           (capture_start),
        .header          (cmd_header),
        .img_d           (img_d),
        .img_fv          (img_fv),
        .img_lv          (img_lv),
        .wr_en           (cap_wr_en),
        .wr_data         (cap_wr_data),
        .done            (cap_done),
        .word_count      (status_capture_word_count),
        .highlight_count (status_capture_highlight_count),
        .shadow_count    (status_capture_shadow_count)
    );

    // Word count of the last capture sets the readout length
    frame_buffer u_buffer (
        .clk             (clk),
        .arst_n          (arst_n),
        .capture_start   (capture_start),
        .capture_block   (block_q),
        .wr_en           (cap_wr_en),
        .wr_data         (cap_wr_data),
        .readout_go      (readout_go),
        .readout_block   (block_q),
        .readout_count   (status_capture_word_count),
        .readout_trigger (readout_trigger),
        .readout_ready   (readout_ready),
        .readout_data    (readout_data)
    );

endmodule

// ==== tb/img_tests.svh ====
`ifndef IMG_TESTS_SVH
`define IMG_TESTS_SVH

// ==============================
// Frame generator
// ==============================
// Header, then lines of pixels with two idle cycles around each line
task automatic capture_frame(input int blk, input int lines, input int pixels,
                             input bit force_tones, input bit extra_cmd);
    logic [31:0] r;
    pixel_t      px;
    checksum_t   sum;
    bit          origin;
    int          sel;
    int          n;
    int          origins;
    int          waited;
    int          i;
    int          j;
    n = 0;
    origins = 0;
    exp_highlight = 0;
    exp_shadow = 0;
    next_cycle();
    // First word drawn ends up most significant
    for (i = 0; i < `IMG_HEADER_WORDS; i++) begin
        r = next_random();
        cmd_header = {cmd_header[$bits(header_t)-`IMG_WORD_BITS-1:0], r[15:0]};
        exp_mem[blk][n] = r[15:0];
        n++;
    end
    cmd_ram_block = block_t'(blk);
    cmd_capture = 1'b1;
    next_cycle();
    cmd_capture = 1'b0;
    // Header goes out here, a second command lands mid capture
    for (i = 0; i < 20; i++) begin
        cmd_capture = extra_cmd && (i == 10);
        next_cycle();
    end
    img_fv = 1'b1;
    repeat (2) next_cycle();
    for (i = 0; i < lines; i++) begin
        for (j = 0; j < pixels; j++) begin
            r = next_random();
            px = r[`IMG_PIXEL_BITS-1:0];
            origin = (i % tile == 0) && (j % tile == 0);
            sel = origin ? origins % 3 : int'(r[17:16]);
            if (force_tones && sel == 0) begin
                px = px | 12'hfe0;
            end else if (force_tones && sel == 1) begin
                px = px & 12'h01f;
            end
            if (origin) begin
                origins++;
                exp_highlight += tone_match(px, 1'b1);
                exp_shadow += tone_match(px, 1'b0);
            end
            img_d = px;
            img_lv = 1'b1;
            exp_mem[blk][n] = word_t'(px);
            n++;
            next_cycle();
        end
        img_lv = 1'b0;
        img_d = '0;
        repeat (2) next_cycle();
    end
    img_fv = 1'b0;
    sum = fletcher_model(blk, n);
    exp_mem[blk][n] = sum[31:16];
    exp_mem[blk][n+1] = sum[15:0];
    exp_len[blk] = n + 2;

    waited = 0;
    @(negedge clk);
    while (!status_capture_done && waited < 200) begin
        @(negedge clk);
        waited++;
    end
    if (!status_capture_done) begin
        report_failure("status_capture_done never pulsed after the frame ended");
    end
    check("status_capture_word_count", status_capture_word_count,
          `IMG_HEADER_WORDS + lines * pixels + 2);
    check("status_capture_highlight_count", status_capture_highlight_count, exp_highlight);
    check("status_capture_shadow_count", status_capture_shadow_count, exp_shadow);
    @(negedge clk);
    check("status_capture_done", status_capture_done, 0);
    next_cycle();
endtask

// ==============================
// Readout of one block
// ==============================
task automatic read_block(input int blk, input bit withhold);
    logic [31:0] r;
    word_t       held_data;
    bit          held;
    bit          trig;
    int          pulses;
    int          start_at;
    int          idx;
    int          i;
    pulses = 0;
    start_at = -1;
    idx = 0;
    held = 1'b0;
    cmd_ram_block = block_t'(blk);
    cmd_readout = 1'b1;
    // Sample index 0 is the cycle of the command
    for (i = 0; i < 4; i++) begin
        @(negedge clk);
        if (readout_start) begin
            pulses++;
            start_at = i;
        end
        next_cycle();
        cmd_readout = 1'b0;
    end
    check("readout_start pulse count", pulses, 1);
    check("readout_start delay", start_at, 2);

    while (idx < exp_len[blk]) begin
        r = next_random();
        trig = !withhold || (r[1:0] != 2'b00);
        readout_trigger = trig;
        @(negedge clk);
        if (held && !readout_ready) begin
            report_failure("readout_ready dropped while a word was waiting");
            held = 1'b0;
        end
        if (readout_ready) begin
            if (held) begin
                check("readout_data held", readout_data, held_data);
            end
            if (trig) begin
                check($sformatf("readout_data[%0d]", idx), readout_data, exp_mem[blk][idx]);
                idx++;
                held = 1'b0;
            end else begin
                held = 1'b1;
                held_data = readout_data;
            end
        end
        next_cycle();
    end
    readout_trigger = 1'b0;
    // No word beyond the stored count
    for (i = 0; i < 3; i++) begin
        @(negedge clk);
        check("readout_ready after last word", readout_ready, 0);
        next_cycle();
    end
endtask

// ==============================
// Directed tests
// ==============================
task automatic test_reset_state();
    @(negedge clk);
    check("readout_start", readout_start, 0);
    check("readout_ready", readout_ready, 0);
    check("status_capture_done", status_capture_done, 0);
    check("status_capture_word_count", status_capture_word_count, 0);
    check("status_capture_highlight_count", status_capture_highlight_count, 0);
    check("status_capture_shadow_count", status_capture_shadow_count, 0);
    next_cycle();
endtask

// 6 x 8 frame into block 0 with forced tones
task automatic test_capture_tones();
    capture_frame(0, 6, 8, 1'b1, 1'b0);
endtask

task automatic test_readout_block0();
    read_block(0, 1'b0);
endtask

// Block 1 capture with an ignored command, then both blocks under back-pressure
task automatic test_second_frame();
    capture_frame(1, 6, 8, 1'b0, 1'b1);
    read_block(0, 1'b1);
    read_block(1, 1'b1);
endtask

`endif

// ==== tb/img_controller_tb.sv ====
`timescale 1ns/1ps
`include "img_params.svh"

module img_controller_tb;
    import img_frame_pkg::*;
    import img_buf_pkg::*;

    // Two captures and three readouts need well under a thousand cycles
    localparam int max_cycles = 20000;
    localparam int tile = 1 << `IMG_STAT_TILE_BITS;

    logic          clk = 1'b0;
    logic          arst_n;
    logic          cmd_capture;
    logic          cmd_readout;
    block_t        cmd_ram_block;
    header_t       cmd_header;
    pixel_t        img_d;
    logic          img_fv;
    logic          img_lv;
    logic          readout_trigger;
    logic          readout_start;
    logic          readout_ready;
    word_t         readout_data;
    logic          status_capture_done;
    word_count_t   status_capture_word_count;
    stat_count_t   status_capture_highlight_count;
    stat_count_t   status_capture_shadow_count;

    // Expected contents of each block
    word_t         exp_mem [`IMG_BLOCKS][`IMG_BLOCK_WORDS];
    int            exp_len [`IMG_BLOCKS];
    int            exp_highlight;
    int            exp_shadow;
    int            error_count = 0;
    int            check_count = 0;
    int            cycle_count = 0;
    logic [31:0]   rng_state = 32'h9367_db38;

    always #50 clk = ~clk;

    img_controller u_dut (
        .clk                            (clk),
        .arst_n                         (arst_n),
        .cmd_capture                    (cmd_capture),
        .cmd_readout                    (cmd_readout),
        .cmd_ram_block                  (cmd_ram_block),
        .cmd_header                     (cmd_header),
        .img_d                          (img_d),
        .img_fv                         (img_fv),
        .img_lv                         (img_lv),
        .readout_trigger                (readout_trigger),
        .readout_start                  (readout_start),
        .readout_ready                  (readout_ready),
        .readout_data                   (readout_data),
        .status_capture_done            (status_capture_done),
        .status_capture_word_count      (status_capture_word_count),
        .status_capture_highlight_count (status_capture_highlight_count),
        .status_capture_shadow_count    (status_capture_shadow_count)
    );

    // ==============================
    // Helpers and reference models
    // ==============================
    // Inputs change just after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0t: %s = 0x%0h, expected 0x%0h",
                     $realtime, name, actual, expected);
        end
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("Failure at %0t: %s", $realtime, msg);
    endtask

    // Xorshift32
    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // Fletcher-32 over the first count words of a block
    function automatic checksum_t fletcher_model(input int blk, input int count);
        int low_sum;
        int high_sum;
        low_sum = 0;
        high_sum = 0;
        for (int i = 0; i < count; i++) begin
            low_sum = (low_sum + exp_mem[blk][i]) % 65535;
            high_sum = (high_sum + low_sum) % 65535;
        end
        return {high_sum[15:0], low_sum[15:0]};
    endfunction

    // Top seven of twelve bits all ones or all zeros
    function automatic bit tone_match(input pixel_t px, input bit bright);
        return bright ? (px >= 12'hfe0) : (px < 12'h020);
    endfunction

    `include "img_tests.svh"

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == max_cycles) begin
            $display("Timeout after %0d cycles, %0d errors so far", max_cycles, error_count);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        arst_n = 1'b0;
        cmd_capture = 1'b0;
        cmd_readout = 1'b0;
        cmd_ram_block = '0;
        cmd_header = '0;
        img_d = '0;
        img_fv = 1'b0;
        img_lv = 1'b0;
        readout_trigger = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;

        test_reset_state();
        test_capture_tones();
        test_readout_block0();
        test_second_frame();
        repeat (4) next_cycle();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== img_controller.f ====
+incdir+common
+incdir+tb
common/img_frame_pkg.sv
common/img_buf_pkg.sv
capture/fletcher_checksum.sv
capture/pixel_capture.sv
src/frame_buffer.sv
src/img_controller.sv
tb/img_controller_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal --Mdir obj_dir
TOP       = img_controller_tb
FILELIST  = img_controller.f
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Something failed" $(LOG) || ! grep -q "Everything OK" $(LOG); then \
		echo "Simulation FAILED"; \
		exit 1; \
	fi
	@echo "Simulation PASSED"

clean:
	rm -rf obj_dir $(LOG)
